// File: rtl/rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

    localparam int XLEN = 64;

    typedef logic [31:0]     instr_t;
    typedef logic [XLEN-1:0] pc_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [31:0]     imm_t;
    typedef logic [1:0]      mem_size_t;
    typedef logic [6:0]      opcode_t;

    // Major opcodes of the uncompressed encoding
    localparam opcode_t OPCODE_LOAD      = 7'b0000011;
    localparam opcode_t OPCODE_MISC_MEM  = 7'b0001111;
    localparam opcode_t OPCODE_OP_IMM    = 7'b0010011;
    localparam opcode_t OPCODE_AUIPC     = 7'b0010111;
    localparam opcode_t OPCODE_OP_IMM_32 = 7'b0011011;
    localparam opcode_t OPCODE_STORE     = 7'b0100011;
    localparam opcode_t OPCODE_OP        = 7'b0110011;
    localparam opcode_t OPCODE_LUI       = 7'b0110111;
    localparam opcode_t OPCODE_OP_32     = 7'b0111011;
    localparam opcode_t OPCODE_BRANCH    = 7'b1100011;
    localparam opcode_t OPCODE_JALR      = 7'b1100111;
    localparam opcode_t OPCODE_JAL       = 7'b1101111;

    // Selects SUB and SRA/SRAI
    localparam logic [6:0] funct7_alt = 7'b0100000;

    typedef enum logic [2:0] {
        OT_ALU,
        OT_MEM,
        OT_BRANCH,
        OT_JALR,
        OT_AUIPC,
        OT_FENCE_I
    } op_type_e;

    // ALU_ADDSUB is zero so that an idle ALU field reads as all zero
    typedef enum logic [2:0] {
        ALU_ADDSUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SHIFT
    } alu_op_e;

    typedef enum logic [2:0] {
        CMP_EQ,
        CMP_NE,
        CMP_LT,
        CMP_GE,
        CMP_LTU,
        CMP_GEU,
        CMP_JUMP
    } cmp_op_e;

    typedef enum logic {
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

endpackage

`default_nettype wire

// File: rtl/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
    input  rv_decode_pkg::instr_t instr,
    output rv_decode_pkg::imm_t   immediate,
    output logic                  use_imm
);
    import rv_decode_pkg::*;

    opcode_t opcode;
    imm_t    i_imm;
    imm_t    u_imm;
    imm_t    s_imm;
    imm_t    b_imm;
    imm_t    j_imm;

    assign opcode = instr[6:0];

    // All formats take their sign from bit 31
    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign u_imm = {instr[31:12], 12'b0};
    assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        immediate = '0;
        use_imm   = 1'b0;
        case (opcode)
            OPCODE_LOAD, OPCODE_OP_IMM, OPCODE_OP_IMM_32, OPCODE_JALR: begin
                immediate = i_imm;
                use_imm   = 1'b1;
            end
            OPCODE_LUI, OPCODE_AUIPC: begin
                immediate = u_imm;
                use_imm   = 1'b1;
            end
            OPCODE_STORE: begin
                immediate = s_imm;
                use_imm   = 1'b1;
            end
            // Target offsets only, not an ALU operand
            OPCODE_BRANCH: immediate = b_imm;
            OPCODE_JAL:    immediate = j_imm;
            default: begin
                immediate = '0;
                use_imm   = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/alu_op_decode.sv
`timescale 1ns/1ps
`default_nettype none

module alu_op_decode (
    input  rv_decode_pkg::instr_t  instr,
    output logic                   hit,
    output logic                   illegal,
    output logic                   use_rs1,
    output logic                   use_rs2,
    output logic                   use_rd,
    output rv_decode_pkg::alu_op_e alu_op,
    output logic                   adder_subtract,
    output logic                   shift_left,
    output logic                   shift_arith,
    output logic                   is_32
);
    import rv_decode_pkg::*;

    opcode_t    opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    logic       reg_form;
    logic       word_form;
    logic       f7_zero;
    logic       f7_alt;
    logic       f7_ok;
    logic       funct3_ok;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign hit = (opcode == OPCODE_OP_IMM) || (opcode == OPCODE_OP_IMM_32) ||
                 (opcode == OPCODE_OP)     || (opcode == OPCODE_OP_32);

    assign reg_form  = (opcode == OPCODE_OP) || (opcode == OPCODE_OP_32);
    assign word_form = (opcode == OPCODE_OP_IMM_32) || (opcode == OPCODE_OP_32);

    // 64-bit immediate shifts carry shamt[5] in funct7 bit 0
    always_comb begin
        if (reg_form || word_form) begin
            f7_zero = (funct7 == 7'b0);
            f7_alt  = (funct7 == funct7_alt);
        end else begin
            f7_zero = (funct7[6:1] == 6'b0);
            f7_alt  = (funct7[6:1] == funct7_alt[6:1]);
        end
    end

    always_comb begin
        alu_op         = ALU_ADDSUB;
        adder_subtract = 1'b0;
        shift_left     = 1'b0;
        shift_arith    = 1'b0;
        f7_ok          = 1'b1;
        funct3_ok      = 1'b1;
        if (hit) begin
            unique case (funct3)
                3'b000: begin
                    alu_op         = ALU_ADDSUB;
                    adder_subtract = reg_form && f7_alt;
                    f7_ok          = !reg_form || f7_zero || f7_alt;
                end
                3'b001: begin
                    alu_op     = ALU_SHIFT;
                    shift_left = 1'b1;
                    f7_ok      = f7_zero;
                end
                3'b101: begin
                    alu_op      = ALU_SHIFT;
                    shift_arith = f7_alt;
                    f7_ok       = f7_zero || f7_alt;
                end
                3'b010: begin
                    alu_op         = ALU_SLT;
                    adder_subtract = 1'b1;
                    f7_ok          = !reg_form || f7_zero;
                    funct3_ok      = !word_form;
                end
                3'b011: begin
                    alu_op         = ALU_SLTU;
                    adder_subtract = 1'b1;
                    f7_ok          = !reg_form || f7_zero;
                    funct3_ok      = !word_form;
                end
                3'b100: begin
                    alu_op    = ALU_XOR;
                    f7_ok     = !reg_form || f7_zero;
                    funct3_ok = !word_form;
                end
                3'b110: begin
                    alu_op    = ALU_OR;
                    f7_ok     = !reg_form || f7_zero;
                    funct3_ok = !word_form;
                end
                3'b111: begin
                    alu_op    = ALU_AND;
                    f7_ok     = !reg_form || f7_zero;
                    funct3_ok = !word_form;
                end
            endcase
        end
    end

    // MUL/DIV land here through funct7 0000001
    assign illegal = hit && !(f7_ok && funct3_ok);

    assign use_rs1 = hit;
    assign use_rs2 = hit && reg_form;
    assign use_rd  = hit;
    assign is_32   = hit && word_form;

endmodule

`default_nettype wire

// File: rtl/flow_mem_decode.sv
`timescale 1ns/1ps
`default_nettype none

module flow_mem_decode (
    input  rv_decode_pkg::instr_t     instr,
    output logic                      hit,
    output logic                      illegal,
    output logic                      use_rs1,
    output logic                      use_rs2,
    output logic                      use_rd,
    output rv_decode_pkg::op_type_e   op_type,
    output rv_decode_pkg::cmp_op_e    cmp_op,
    output rv_decode_pkg::mem_op_e    mem_op,
    output rv_decode_pkg::mem_size_t  mem_size,
    output logic                      mem_zeroext
);
    import rv_decode_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    always_comb begin
        hit         = 1'b1;
        illegal     = 1'b0;
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        use_rd      = 1'b0;
        op_type     = OT_ALU;
        cmp_op      = CMP_EQ;
        mem_op      = MEM_LOAD;
        mem_size    = '0;
        mem_zeroext = 1'b0;
        case (opcode)
            OPCODE_LOAD: begin
                op_type     = OT_MEM;
                mem_op      = MEM_LOAD;
                mem_size    = funct3[1:0];
                mem_zeroext = funct3[2];
                use_rs1     = 1'b1;
                use_rd      = 1'b1;
                // No LDU in RV64
                illegal     = (funct3 == 3'b111);
            end
            OPCODE_STORE: begin
                op_type  = OT_MEM;
                mem_op   = MEM_STORE;
                mem_size = funct3[1:0];
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
                illegal  = funct3[2];
            end
            OPCODE_BRANCH: begin
                op_type = OT_BRANCH;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                case (funct3)
                    3'b000:  cmp_op = CMP_EQ;
                    3'b001:  cmp_op = CMP_NE;
                    3'b100:  cmp_op = CMP_LT;
                    3'b101:  cmp_op = CMP_GE;
                    3'b110:  cmp_op = CMP_LTU;
                    3'b111:  cmp_op = CMP_GEU;
                    default: illegal = 1'b1;
                endcase
            end
            OPCODE_JAL: begin
                op_type = OT_BRANCH;
                cmp_op  = CMP_JUMP;
                use_rd  = 1'b1;
            end
            OPCODE_JALR: begin
                op_type = OT_JALR;
                use_rs1 = 1'b1;
                use_rd  = 1'b1;
                illegal = (funct3 != 3'b000);
            end
            OPCODE_AUIPC: begin
                op_type = OT_AUIPC;
                use_rd  = 1'b1;
            end
            // Executed by the ALU as zero plus the immediate
            OPCODE_LUI: use_rd = 1'b1;
            OPCODE_MISC_MEM: begin
                case (funct3)
                    // FENCE is a no-op on this in-order core
                    3'b000:  op_type = OT_ALU;
                    3'b001:  op_type = OT_FENCE_I;
                    default: illegal = 1'b1;
                endcase
            end
            default: hit = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  rv_decode_pkg::instr_t     instr,
    input  rv_decode_pkg::pc_t        pc,
    output logic                      out_valid,
    output rv_decode_pkg::pc_t        out_pc,
    output rv_decode_pkg::op_type_e   op_type,
    output rv_decode_pkg::alu_op_e    alu_op,
    output logic                      adder_subtract,
    output logic                      shift_left,
    output logic                      shift_arith,
    output logic                      is_32,
    output rv_decode_pkg::cmp_op_e    cmp_op,
    output rv_decode_pkg::mem_op_e    mem_op,
    output rv_decode_pkg::mem_size_t  mem_size,
    output logic                      mem_zeroext,
    output rv_decode_pkg::reg_idx_t   rs1,
    output rv_decode_pkg::reg_idx_t   rs2,
    output rv_decode_pkg::reg_idx_t   rd,
    output logic                      use_imm,
    output rv_decode_pkg::imm_t       immediate,
    output logic                      illegal
);
    import rv_decode_pkg::*;

    logic      alu_hit, alu_illegal, alu_use_rs1, alu_use_rs2, alu_use_rd;
    alu_op_e   alu_alu_op;
    logic      alu_adder_subtract, alu_shift_left, alu_shift_arith, alu_is_32;
    logic      flow_hit, flow_illegal, flow_use_rs1, flow_use_rs2, flow_use_rd;
    op_type_e  flow_op_type;
    cmp_op_e   flow_cmp_op;
    mem_op_e   flow_mem_op;
    mem_size_t flow_mem_size;
    logic      flow_mem_zeroext;
    imm_t      imm_value;
    logic      imm_use;
    logic      use_rs1, use_rs2, use_rd;

    imm_gen i_imm_gen (
        .instr     (instr),
        .immediate (imm_value),
        .use_imm   (imm_use)
    );

    alu_op_decode i_alu_op_decode (
        .instr          (instr),
        .hit            (alu_hit),
        .illegal        (alu_illegal),
        .use_rs1        (alu_use_rs1),
        .use_rs2        (alu_use_rs2),
        .use_rd         (alu_use_rd),
        .alu_op         (alu_alu_op),
        .adder_subtract (alu_adder_subtract),
        .shift_left     (alu_shift_left),
        .shift_arith    (alu_shift_arith),
        .is_32          (alu_is_32)
    );

    flow_mem_decode i_flow_mem_decode (
        .instr       (instr),
        .hit         (flow_hit),
        .illegal     (flow_illegal),
        .use_rs1     (flow_use_rs1),
        .use_rs2     (flow_use_rs2),
        .use_rd      (flow_use_rd),
        .op_type     (flow_op_type),
        .cmp_op      (flow_cmp_op),
        .mem_op      (flow_mem_op),
        .mem_size    (flow_mem_size),
        .mem_zeroext (flow_mem_zeroext)
    );

    assign use_rs1 = (alu_hit && alu_use_rs1) || (flow_hit && flow_use_rs1);
    assign use_rs2 = (alu_hit && alu_use_rs2) || (flow_hit && flow_use_rs2);
    assign use_rd  = (alu_hit && alu_use_rd)  || (flow_hit && flow_use_rd);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Payload only loads on a valid word and holds otherwise
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_pc         <= pc;
            op_type        <= flow_hit ? flow_op_type : OT_ALU;
            alu_op         <= alu_hit ? alu_alu_op : ALU_ADDSUB;
            adder_subtract <= alu_hit && alu_adder_subtract;
            shift_left     <= alu_hit && alu_shift_left;
            shift_arith    <= alu_hit && alu_shift_arith;
            is_32          <= alu_hit && alu_is_32;
            cmp_op         <= flow_hit ? flow_cmp_op : CMP_EQ;
            mem_op         <= flow_hit ? flow_mem_op : MEM_LOAD;
            mem_size       <= flow_hit ? flow_mem_size : mem_size_t'(0);
            mem_zeroext    <= flow_hit && flow_mem_zeroext;
            rs1            <= use_rs1 ? instr[19:15] : reg_idx_t'(0);
            rs2            <= use_rs2 ? instr[24:20] : reg_idx_t'(0);
            rd             <= use_rd ? instr[11:7] : reg_idx_t'(0);
            use_imm        <= imm_use;
            immediate      <= imm_value;
            // Unclaimed opcodes, SYSTEM and AMO included
            illegal        <= alu_hit ? alu_illegal : (flow_hit ? flow_illegal : 1'b1);
        end
    end

    // Opcode sets of the two decoders are disjoint
    assert property (@(posedge clk) disable iff (!rst_n) !(alu_hit && flow_hit));

    assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(out_valid));

    assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid && !alu_hit && !flow_hit) |=> (out_valid && illegal));

endmodule

`default_nettype wire

// File: verification/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// One expected result per valid input word
typedef struct packed {
    pc_t       pc;
    op_type_e  op_type;
    alu_op_e   alu_op;
    logic      adder_subtract;
    logic      shift_left;
    logic      shift_arith;
    logic      is_32;
    cmp_op_e   cmp_op;
    mem_op_e   mem_op;
    mem_size_t mem_size;
    logic      mem_zeroext;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    logic      use_imm;
    imm_t      immediate;
    logic      illegal;
} decode_exp_t;

localparam opcode_t kept_opcodes [12] = '{
    OPCODE_LOAD, OPCODE_MISC_MEM, OPCODE_OP_IMM, OPCODE_AUIPC,
    OPCODE_OP_IMM_32, OPCODE_STORE, OPCODE_OP, OPCODE_LUI,
    OPCODE_OP_32, OPCODE_BRANCH, OPCODE_JALR, OPCODE_JAL
};

// Zero, SUB/SRA, MUL group and an odd value
localparam logic [6:0] funct7_choices [4] = '{7'h00, funct7_alt, 7'h01, 7'h21};

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

// Bit 32 is the use-immediate flag
function automatic logic [32:0] model_immediate(input instr_t w);
    case (opcode_t'(w[6:0]))
        OPCODE_LOAD, OPCODE_OP_IMM, OPCODE_OP_IMM_32, OPCODE_JALR:
            return {1'b1, 32'($signed(w[31:20]))};
        OPCODE_LUI, OPCODE_AUIPC:
            return {1'b1, w[31:12], 12'h000};
        OPCODE_STORE:
            return {1'b1, 32'($signed({w[31:25], w[11:7]}))};
        OPCODE_BRANCH:
            return {1'b0, 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}))};
        OPCODE_JAL:
            return {1'b0, 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}))};
        default:
            return 33'd0;
    endcase
endfunction

function automatic decode_exp_t model_decode(input instr_t w, input pc_t p);
    decode_exp_t e;
    opcode_t     op;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [32:0] im;
    logic        reg_grp;
    logic        word_grp;
    logic        sh_free;
    logic        f7_zero;
    logic        f7_alt;
    op = w[6:0];
    f3 = w[14:12];
    f7 = w[31:25];
    im = model_immediate(w);
    // All-zero fields stand for OT_ALU, ALU_ADDSUB, CMP_EQ and MEM_LOAD
    e = '0;
    e.pc = p;
    e.use_imm = im[32];
    e.immediate = im[31:0];
    e.illegal = 1'b1;
    reg_grp = (op == OPCODE_OP) || (op == OPCODE_OP_32);
    word_grp = (op == OPCODE_OP_IMM_32) || (op == OPCODE_OP_32);
    if (reg_grp || word_grp || op == OPCODE_OP_IMM) begin
        // RV64 immediate shifts use funct7 bit 0 as shamt[5]
        sh_free = (op == OPCODE_OP_IMM) && (f3 == 3'b001 || f3 == 3'b101);
        f7_zero = sh_free ? (f7[6:1] == 6'd0) : (f7 == 7'd0);
        f7_alt = sh_free ? (f7[6:1] == funct7_alt[6:1]) : (f7 == funct7_alt);
        e.rs1 = w[19:15];
        e.rs2 = reg_grp ? w[24:20] : 5'd0;
        e.rd = w[11:7];
        e.is_32 = word_grp;
        case (f3)
            3'b000: begin
                e.adder_subtract = reg_grp && f7_alt;
                e.illegal = reg_grp && !f7_zero && !f7_alt;
            end
            3'b001: begin
                e.alu_op = ALU_SHIFT;
                e.shift_left = 1'b1;
                e.illegal = !f7_zero;
            end
            3'b101: begin
                e.alu_op = ALU_SHIFT;
                e.shift_arith = f7_alt;
                e.illegal = !f7_zero && !f7_alt;
            end
            default: begin
                case (f3)
                    3'b010:  e.alu_op = ALU_SLT;
                    3'b011:  e.alu_op = ALU_SLTU;
                    3'b100:  e.alu_op = ALU_XOR;
                    3'b110:  e.alu_op = ALU_OR;
                    default: e.alu_op = ALU_AND;
                endcase
                e.adder_subtract = (f3[2:1] == 2'b01);
                // No SLT, XOR, OR or AND forms in the word groups
                e.illegal = word_grp || (reg_grp && !f7_zero);
            end
        endcase
    end else begin
        case (op)
            OPCODE_LOAD: begin
                e.op_type = OT_MEM;
                e.mem_size = f3[1:0];
                e.mem_zeroext = f3[2];
                e.rs1 = w[19:15];
                e.rd = w[11:7];
                e.illegal = (f3 == 3'b111);
            end
            OPCODE_STORE: begin
                e.op_type = OT_MEM;
                e.mem_op = MEM_STORE;
                e.mem_size = f3[1:0];
                e.rs1 = w[19:15];
                e.rs2 = w[24:20];
                e.illegal = f3[2];
            end
            OPCODE_BRANCH: begin
                e.op_type = OT_BRANCH;
                e.rs1 = w[19:15];
                e.rs2 = w[24:20];
                e.illegal = (f3[2:1] == 2'b01);
                case (f3)
                    3'b001:  e.cmp_op = CMP_NE;
                    3'b100:  e.cmp_op = CMP_LT;
                    3'b101:  e.cmp_op = CMP_GE;
                    3'b110:  e.cmp_op = CMP_LTU;
                    3'b111:  e.cmp_op = CMP_GEU;
                    default: e.cmp_op = CMP_EQ;
                endcase
            end
            OPCODE_JAL: begin
                e.op_type = OT_BRANCH;
                e.cmp_op = CMP_JUMP;
                e.rd = w[11:7];
                e.illegal = 1'b0;
            end
            OPCODE_JALR: begin
                e.op_type = OT_JALR;
                e.rs1 = w[19:15];
                e.rd = w[11:7];
                e.illegal = (f3 != 3'b000);
            end
            OPCODE_AUIPC: begin
                e.op_type = OT_AUIPC;
                e.rd = w[11:7];
                e.illegal = 1'b0;
            end
            OPCODE_LUI: begin
                e.rd = w[11:7];
                e.illegal = 1'b0;
            end
            OPCODE_MISC_MEM: begin
                e.op_type = (f3 == 3'b001) ? OT_FENCE_I : OT_ALU;
                e.illegal = (f3[2:1] != 2'b00);
            end
            default: begin
                e.illegal = 1'b1;
            end
        endcase
    end
    return e;
endfunction

`endif

// File: verification/tb_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;
    import rv_decode_pkg::*;

    `include "decode_model.svh"

    localparam int          clk_period  = 4;
    localparam int          num_words   = 3000;
    localparam int          drain_limit = 20;
    localparam logic [31:0] seed        = 32'd64309;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      in_valid;
    instr_t    instr;
    pc_t       pc;
    logic      out_valid;
    pc_t       out_pc;
    op_type_e  op_type;
    alu_op_e   alu_op;
    logic      adder_subtract;
    logic      shift_left;
    logic      shift_arith;
    logic      is_32;
    cmp_op_e   cmp_op;
    mem_op_e   mem_op;
    mem_size_t mem_size;
    logic      mem_zeroext;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    logic      use_imm;
    imm_t      immediate;
    logic      illegal;

    decode_exp_t expected_q[$];
    logic        expect_valid;

    decode_stage i_dut (.*);

    always #(clk_period / 2) clk = ~clk;

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "decode output check failed");
        end
    endtask

    task automatic compare_outputs(input decode_exp_t e);
        check_field("out_pc", out_pc, e.pc);
        check_field("op_type", 64'(op_type), 64'(e.op_type));
        check_field("alu_op", 64'(alu_op), 64'(e.alu_op));
        check_field("adder_subtract", 64'(adder_subtract), 64'(e.adder_subtract));
        check_field("shift_left", 64'(shift_left), 64'(e.shift_left));
        check_field("shift_arith", 64'(shift_arith), 64'(e.shift_arith));
        check_field("is_32", 64'(is_32), 64'(e.is_32));
        check_field("cmp_op", 64'(cmp_op), 64'(e.cmp_op));
        check_field("mem_op", 64'(mem_op), 64'(e.mem_op));
        check_field("mem_size", 64'(mem_size), 64'(e.mem_size));
        check_field("mem_zeroext", 64'(mem_zeroext), 64'(e.mem_zeroext));
        check_field("rs1", 64'(rs1), 64'(e.rs1));
        check_field("rs2", 64'(rs2), 64'(e.rs2));
        check_field("rd", 64'(rd), 64'(e.rd));
        check_field("use_imm", 64'(use_imm), 64'(e.use_imm));
        check_field("immediate", 64'(immediate), 64'(e.immediate));
        check_field("illegal", 64'(illegal), 64'(e.illegal));
    endtask

    // Called at the falling edge, half a cycle after the outputs settle
    task automatic sample_outputs();
        decode_exp_t e;
        check_field("out_valid", 64'(out_valid), 64'(expect_valid));
        if (out_valid === 1'b1) begin
            e = expected_q.pop_front();
            compare_outputs(e);
        end
    endtask

    initial begin
        #((num_words + 100) * clk_period);
        $display("simulation ran past its time limit");
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] rng;
        logic [31:0] sel;
        logic [31:0] word;
        logic [6:0]  pick;
        int          idx;
        rst_n = 1'b0;
        in_valid = 1'b0;
        instr = '0;
        pc = '0;
        expect_valid = 1'b0;
        rng = seed;
        repeat (2) begin
            @(negedge clk);
            sample_outputs();
        end
        rst_n = 1'b1;
        // Nothing may come out before the first valid word
        repeat (3) begin
            @(negedge clk);
            sample_outputs();
        end
        for (int n = 0; n < num_words; n++) begin
            @(negedge clk);
            sample_outputs();
            rng = xorshift32(rng);
            word = rng;
            rng = xorshift32(rng);
            sel = rng;
            if (sel[1:0] != 2'b00) begin
                idx = int'(sel[31:8] % 24'd12);
                word[6:0] = kept_opcodes[idx];
            end
            if (sel[4] && (word[6:0] inside {OPCODE_OP, OPCODE_OP_32, OPCODE_OP_IMM,
                                             OPCODE_OP_IMM_32})) begin
                pick = funct7_choices[sel[6:5]];
                word[31:26] = pick[6:1];
                if (!sel[7]) begin
                    word[25] = pick[0];
                end
            end
            rng = xorshift32(rng);
            pc[63:32] = rng;
            rng = xorshift32(rng);
            pc[31:0] = rng;
            rng = xorshift32(rng);
            in_valid = (rng[1:0] != 2'b00);
            instr = word;
            if (in_valid) begin
                expected_q.push_back(model_decode(word, pc));
            end
            expect_valid = in_valid;
        end
        for (int t = 0; t < drain_limit && expected_q.size() != 0; t++) begin
            @(negedge clk);
            sample_outputs();
            in_valid = 1'b0;
            expect_valid = 1'b0;
        end
        if (expected_q.size() != 0) begin
            $display("drain timed out with %0d results outstanding", expected_q.size());
            $display("TESTS FAILED");
            $fatal(1, "drain timeout");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+verification
rtl/rv_decode_pkg.sv
rtl/imm_gen.sv
rtl/alu_op_decode.sv
rtl/flow_mem_decode.sv
rtl/decode_stage.sv
verification/tb_decode_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FLAGS     ?= --binary --timing --assert
BUILD_DIR ?= obj_dir

.PHONY: sim clean

# The run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f sim.f
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)
